/* build.f */
dma_job_pkg.sv
dma_page_pkg.sv
dma_reg_frontend.sv
dma_job_fifo.sv
dma_page_splitter.sv
dma_rsp_merger.sv
dma_core.sv
dma_core_checker.sv
tb_dma_core.sv

/* dma_core.sv */
// Top level of the DMA job path from register port to fragment port
module dma_core import dma_job_pkg::*, dma_page_pkg::*; (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  reg_req_t      reg_req_i,
  output reg_rsp_t      reg_rsp_o,
  output dma_frag_t     frag_o,
  output logic          frag_valid_o,
  input  logic          frag_ready_i,
  input  logic          rsp_valid_i,
  input  dma_frag_rsp_t rsp_i
);

  dma_job_t            job, head;
  dma_retire_t         retire_info;
  logic [LenWidth-1:0] count;
  logic                push, credit, not_empty, pop;
  logic                count_push, merge_space, retire;

  dma_reg_frontend i_reg_frontend (
    .clk_i,
    .rst_n_i,
    .reg_req_i,
    .reg_rsp_o,
    .push_o        ( push        ),
    .job_o         ( job         ),
    .credit_i      ( credit      ),
    .retire_i      ( retire      ),
    .retire_info_i ( retire_info )
  );

  dma_job_fifo i_job_fifo (
    .clk_i,
    .rst_n_i,
    .push_i      ( push      ),
    .job_i       ( job       ),
    .credit_o    ( credit    ),
    .head_o      ( head      ),
    .not_empty_o ( not_empty ),
    .pop_i       ( pop       )
  );

  dma_page_splitter i_page_splitter (
    .clk_i,
    .rst_n_i,
    .head_i        ( head        ),
    .not_empty_i   ( not_empty   ),
    .pop_o         ( pop         ),
    .frag_o,
    .frag_valid_o,
    .frag_ready_i,
    .count_push_o  ( count_push  ),
    .count_o       ( count       ),
    .merge_space_i ( merge_space )
  );

  dma_rsp_merger i_rsp_merger (
    .clk_i,
    .rst_n_i,
    .count_push_i  ( count_push  ),
    .count_i       ( count       ),
    .space_o       ( merge_space ),
    .rsp_valid_i,
    .rsp_i,
    .retire_o      ( retire      ),
    .retire_info_o ( retire_info )
  );

endmodule

/* dma_core_checker.sv */
// Concurrent assertions on the fragment handshake, job credits and reset state, with the bind
module dma_core_checker import dma_job_pkg::*, dma_page_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input dma_frag_t frag_o,
  input logic      frag_valid_o,
  input logic      frag_ready_i,
  input logic      push_i,
  input logic      credit_i
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [CreditWidth-1:0] credits_used;

  // Jobs pushed and not yet given back as credits
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credits_used <= '0;
    end else begin
      credits_used <= credits_used + CreditWidth'(push_i) - CreditWidth'(credit_i);
    end
  end

  // Stalled fragment stays offered and unchanged
  frag_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    frag_valid_o && !frag_ready_i |=> frag_valid_o && $stable(frag_o))
    else $error("fragment changed or dropped while the mover stalled");

  credit_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> credits_used < CreditWidth'(JobFifoDepth))
    else $error("job pushed into the FIFO with no credit left");

  reset_a: assert property (@(posedge clk_i) !rst_n_i |-> !frag_valid_o)
    else $error("frag_valid_o high during reset");

endmodule

bind dma_core dma_core_checker i_checker (
  .clk_i,
  .rst_n_i,
  .frag_o,
  .frag_valid_o,
  .frag_ready_i,
  .push_i   ( push   ),
  .credit_i ( credit )
);

/* dma_job_fifo.sv */
// Credit-fed job FIFO that returns one credit per pop
module dma_job_fifo import dma_job_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     push_i,
  input  dma_job_t job_i,
  output logic     credit_o,
  output dma_job_t head_o,
  output logic     not_empty_o,
  input  logic     pop_i
);

  dma_job_t                mem_q [JobFifoDepth];
  logic [FifoPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CreditWidth-1:0]  level_q;
  logic                    pop;
  logic                    credit_q;

  assign not_empty_o = (level_q != '0);
  assign pop = pop_i & not_empty_o;
  assign head_o = mem_q[rd_ptr_q];
  assign credit_o = credit_q;

  // Frontend credits guarantee a free slot on every push
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= job_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == FifoPtrWidth'(JobFifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == FifoPtrWidth'(JobFifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      level_q <= level_q + CreditWidth'(push_i) - CreditWidth'(pop);
      // Freed slot goes back as a credit
      credit_q <= pop;
    end
  end

endmodule

/* dma_job_pkg.sv */
// Job register map, job and register port types, job queue depth
package dma_job_pkg;

  localparam int unsigned AddrWidth    = 48;
  localparam int unsigned LenWidth     = 32;
  // ID 0 is never issued and reads as "not launched"
  localparam int unsigned IdWidth      = 32;
  localparam int unsigned JobFifoDepth = 4;
  localparam int unsigned RegAddrWidth = 6;
  localparam int unsigned RegDataWidth = 64;
  localparam int unsigned CreditWidth  = $clog2(JobFifoDepth + 1);
  localparam int unsigned FifoPtrWidth = $clog2(JobFifoDepth);

  // Byte offsets of the 64-bit registers
  localparam logic [RegAddrWidth-1:0] RegSrc    = 6'h00;
  localparam logic [RegAddrWidth-1:0] RegDst    = 6'h08;
  localparam logic [RegAddrWidth-1:0] RegLen    = 6'h10;
  localparam logic [RegAddrWidth-1:0] RegNextId = 6'h18;
  localparam logic [RegAddrWidth-1:0] RegDoneId = 6'h20;
  localparam logic [RegAddrWidth-1:0] RegStatus = 6'h28;

  typedef struct packed {
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    logic [LenWidth-1:0]  len;
  } dma_job_t;

  typedef struct packed {
    logic                    valid;
    logic                    write;
    logic [RegAddrWidth-1:0] addr;
    logic [RegDataWidth-1:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [RegDataWidth-1:0] rdata;
  } reg_rsp_t;

endpackage

/* dma_page_pkg.sv */
// Page geometry, merge queue depth, fragment, fragment response and retirement types
package dma_page_pkg;

  import dma_job_pkg::*;

  // 4 KiB pages
  localparam int unsigned PageWidth = 12;
  localparam logic [PageWidth:0] PageBytes = {1'b1, {PageWidth{1'b0}}};

  // Jobs queued in the FIFO, one being split, one draining
  localparam int unsigned MergeDepth    = JobFifoDepth + 2;
  localparam int unsigned MergePtrWidth = $clog2(MergeDepth);
  localparam int unsigned MergeLvlWidth = $clog2(MergeDepth + 1);

  typedef struct packed {
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    logic [LenWidth-1:0]  len;
    logic                 last;
  } dma_frag_t;

  typedef struct packed {
    logic error;
  } dma_frag_rsp_t;

  // Sent along with the retire pulse of a job
  typedef struct packed {
    logic error;
  } dma_retire_t;

endpackage

/* dma_page_splitter.sv */
// Page splitter that cuts one job at a time into page-bounded fragments
module dma_page_splitter import dma_job_pkg::*, dma_page_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  dma_job_t            head_i,
  input  logic                not_empty_i,
  output logic                pop_o,
  output dma_frag_t           frag_o,
  output logic                frag_valid_o,
  input  logic                frag_ready_i,
  output logic                count_push_o,
  output logic [LenWidth-1:0] count_o,
  input  logic                merge_space_i
);

  logic                 busy_q;
  logic [AddrWidth-1:0] src_q, dst_q;
  logic [LenWidth-1:0]  rem_q, cnt_q;
  logic [PageWidth:0]   src_left, dst_left, page_left;
  logic [LenWidth-1:0]  page_left_ext, frag_len;
  logic                 last, fire;

  // Bytes up to the next page boundary on each side
  assign src_left = PageBytes - {1'b0, src_q[PageWidth-1:0]};
  assign dst_left = PageBytes - {1'b0, dst_q[PageWidth-1:0]};
  assign page_left = (src_left < dst_left) ? src_left : dst_left;
  assign page_left_ext = {{(LenWidth - PageWidth - 1){1'b0}}, page_left};

  assign last = (rem_q <= page_left_ext);
  assign frag_len = last ? rem_q : page_left_ext;

  assign pop_o = ~busy_q & not_empty_i;
  // Last fragment held back until the merger can take its count
  assign frag_valid_o = busy_q & (~last | merge_space_i);
  assign fire = frag_valid_o & frag_ready_i;
  assign frag_o = '{src: src_q, dst: dst_q, len: frag_len, last: last};

  assign count_push_o = fire & last;
  assign count_o = cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (pop_o) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (fire) begin
      cnt_q <= cnt_q + 1'b1;
      if (last) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Walking addresses and remaining length
  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      src_q <= head_i.src;
      dst_q <= head_i.dst;
      rem_q <= head_i.len;
    end else if (fire) begin
      src_q <= src_q + AddrWidth'(frag_len);
      dst_q <= dst_q + AddrWidth'(frag_len);
      rem_q <= rem_q - frag_len;
    end
  end

endmodule

/* dma_reg_frontend.sv */
// Register frontend with job launch, credit counter, transfer ID counters and status
module dma_reg_frontend import dma_job_pkg::*, dma_page_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  reg_req_t    reg_req_i,
  output reg_rsp_t    reg_rsp_o,
  output logic        push_o,
  output dma_job_t    job_o,
  input  logic        credit_i,
  input  logic        retire_i,
  input  dma_retire_t retire_info_i
);

  logic [AddrWidth-1:0]   src_q, dst_q;
  logic [LenWidth-1:0]    len_q;
  logic [CreditWidth-1:0] credit_q;
  logic [IdWidth-1:0]     next_id_q, done_id_q, new_id;
  logic                   err_q;
  logic                   wr_en, rd_en, launch, status_rd, busy;

  assign wr_en = reg_req_i.valid & reg_req_i.write;
  assign rd_en = reg_req_i.valid & ~reg_req_i.write;

  // Launch needs a free FIFO slot and a nonzero length
  assign launch = rd_en && (reg_req_i.addr == RegNextId) && (credit_q != '0) && (len_q != '0);
  assign status_rd = rd_en && (reg_req_i.addr == RegStatus);
  assign new_id = next_id_q + 1'b1;
  assign busy = (next_id_q != done_id_q);

  assign push_o = launch;
  assign job_o = '{src: src_q, dst: dst_q, len: len_q};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.addr)
        RegSrc:  src_q <= reg_req_i.wdata[AddrWidth-1:0];
        RegDst:  dst_q <= reg_req_i.wdata[AddrWidth-1:0];
        RegLen:  len_q <= reg_req_i.wdata[LenWidth-1:0];
        default: ;
      endcase
    end
  end

  // One credit per push, one back per FIFO pop
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_q <= CreditWidth'(JobFifoDepth);
    end else begin
      credit_q <= credit_q - CreditWidth'(launch) + CreditWidth'(credit_i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      next_id_q <= '0;
      done_id_q <= '0;
      err_q     <= 1'b0;
    end else begin
      if (launch) begin
        next_id_q <= new_id;
      end
      if (retire_i) begin
        done_id_q <= done_id_q + 1'b1;
      end
      // Sticky error, a new error beats the clear on read
      err_q <= (err_q & ~status_rd) | (retire_i & retire_info_i.error);
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    if (rd_en) begin
      case (reg_req_i.addr)
        RegSrc:    reg_rsp_o.rdata = RegDataWidth'(src_q);
        RegDst:    reg_rsp_o.rdata = RegDataWidth'(dst_q);
        RegLen:    reg_rsp_o.rdata = RegDataWidth'(len_q);
        RegNextId: reg_rsp_o.rdata = launch ? RegDataWidth'(new_id) : '0;
        RegDoneId: reg_rsp_o.rdata = RegDataWidth'(done_id_q);
        RegStatus: reg_rsp_o.rdata = RegDataWidth'({err_q, busy});
        default:   reg_rsp_o.rdata = '0;
      endcase
    end
  end

endmodule

/* dma_rsp_merger.sv */
// Response merger that turns per-fragment responses into job retirements
module dma_rsp_merger import dma_job_pkg::*, dma_page_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                count_push_i,
  input  logic [LenWidth-1:0] count_i,
  output logic                space_o,
  input  logic                rsp_valid_i,
  input  dma_frag_rsp_t       rsp_i,
  output logic                retire_o,
  output dma_retire_t         retire_info_o
);

  logic [LenWidth-1:0]      cnt_mem_q [MergeDepth];
  logic [MergePtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [MergeLvlWidth-1:0] level_q;
  logic [LenWidth-1:0]      head_cnt, rsp_cnt_q;
  logic                     head_vld, err_q, done, wr_en, rd_en;
  logic                     retire_q;
  dma_retire_t              retire_info_q;

  // Empty queue looks straight at the count pushed this cycle
  assign head_vld = (level_q != '0) | count_push_i;
  assign head_cnt = (level_q != '0) ? cnt_mem_q[rd_ptr_q] : count_i;
  assign done = rsp_valid_i & head_vld & ((rsp_cnt_q + 1'b1) == head_cnt);

  assign wr_en = count_push_i & ~(done & (level_q == '0));
  assign rd_en = done & (level_q != '0);
  assign space_o = (level_q != MergeLvlWidth'(MergeDepth));

  assign retire_o = retire_q;
  assign retire_info_o = retire_info_q;

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      cnt_mem_q[wr_ptr_q] <= count_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      level_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == MergePtrWidth'(MergeDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == MergePtrWidth'(MergeDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      level_q <= level_q + MergeLvlWidth'(wr_en) - MergeLvlWidth'(rd_en);
    end
  end

  // Responses counted and errors ORed for the head job
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_cnt_q     <= '0;
      err_q         <= 1'b0;
      retire_q      <= 1'b0;
      retire_info_q <= '0;
    end else begin
      retire_q <= done;
      if (done) begin
        retire_info_q.error <= err_q | rsp_i.error;
        rsp_cnt_q <= '0;
        err_q     <= 1'b0;
      end else if (rsp_valid_i) begin
        rsp_cnt_q <= rsp_cnt_q + 1'b1;
        err_q     <= err_q | rsp_i.error;
      end
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and judge the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_dma_core -f build.f \
  && ./obj_dir/Vtb_dma_core | tee sim.log \
  || echo "build or simulation returned an error" >> sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0

/* tb_dma_core.sv */
// Testbench for the DMA core with a job table, a data-mover model, checks and the run timeout
module tb_dma_core import dma_job_pkg::*, dma_page_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [AddrWidth-1:0] src;
    logic [AddrWidth-1:0] dst;
    logic [LenWidth-1:0]  len;
    logic                 inject_err;
    logic [7:0]           num_frags;
  } row_t;

  localparam int NumRows = 5;
  localparam int TimeoutCycles = 200 * NumRows + 500;
  localparam logic [LenWidth-1:0] PageSize = 1 << PageWidth;

  logic          clk_i = 1'b0;
  logic          rst_n_i;
  reg_req_t      reg_req_i;
  reg_rsp_t      reg_rsp_o;
  dma_frag_t     frag_o;
  logic          frag_valid_o, frag_ready_i, rsp_valid_i;
  dma_frag_rsp_t rsp_i;

  row_t               rows [NumRows];
  dma_frag_t          frag_q[$], exp_q[$];
  logic               rsp_q[$], job_err_q[$];
  logic               hold_ready = 1'b0;
  logic               first_frag = 1'b1;
  integer             seed = 32'hf2fda0d6;
  int                 cycles = 0;
  int                 frag_cnt = 0;
  int                 pass_cnt = 0;
  int                 fail_cnt = 0;
  logic [IdWidth-1:0] last_id = '0;

  dma_core dut0 (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Data mover drives ready and responses just after the edge
  always @(posedge clk_i) begin
    #1;
    frag_ready_i = rst_n_i && !hold_ready && (($random(seed) & 3) != 0);
    rsp_valid_i = 1'b0;
    rsp_i = '0;
    if (rsp_q.size() != 0 && ($random(seed) & 1)) begin
      rsp_valid_i = 1'b1;
      rsp_i.error = rsp_q.pop_front();
    end
  end

  // Fragments that move at the next edge
  always @(negedge clk_i) begin
    if (rst_n_i && frag_valid_o && frag_ready_i) begin
      frag_q.push_back(frag_o);
      frag_cnt++;
      // Error only on the first fragment of a job
      if (first_frag && job_err_q.size() != 0) begin
        rsp_q.push_back(job_err_q.pop_front());
      end else begin
        rsp_q.push_back(1'b0);
      end
      first_frag = frag_o.last;
    end
  end

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected %h actual %h", name, expected, actual);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic reg_write(input logic [RegAddrWidth-1:0] addr, input logic [63:0] data);
    @(posedge clk_i);
    #1;
    reg_req_i = '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
  endtask

  task automatic reg_read(input logic [RegAddrWidth-1:0] addr, output logic [63:0] data);
    @(posedge clk_i);
    #1;
    reg_req_i = '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
    #2;
    data = reg_rsp_o.rdata;
  endtask

  task automatic reg_idle();
    @(posedge clk_i);
    #1;
    reg_req_i = '0;
  endtask

  // No fragment may cross a page on either side
  task automatic build_expected(input logic [AddrWidth-1:0] src, input logic [AddrWidth-1:0] dst,
                                input logic [LenWidth-1:0] len);
    logic [AddrWidth-1:0] s, d;
    logic [LenWidth-1:0]  rem, n;
    s = src;
    d = dst;
    rem = len;
    while (rem != '0) begin
      n = rem;
      if (PageSize - s[PageWidth-1:0] < n) n = PageSize - s[PageWidth-1:0];
      if (PageSize - d[PageWidth-1:0] < n) n = PageSize - d[PageWidth-1:0];
      exp_q.push_back('{src: s, dst: d, len: n, last: (n == rem)});
      s = s + AddrWidth'(n);
      d = d + AddrWidth'(n);
      rem = rem - n;
    end
  endtask

  task automatic compare_frags(input logic [LenWidth-1:0] len);
    dma_frag_t           got, want;
    logic [LenWidth-1:0] sum;
    sum = '0;
    while (frag_q.size() < exp_q.size()) @(posedge clk_i);
    while (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      got = frag_q.pop_front();
      compare_value("frag_o.src", 64'(want.src), 64'(got.src));
      compare_value("frag_o.dst", 64'(want.dst), 64'(got.dst));
      compare_value("frag_o.len", 64'(want.len), 64'(got.len));
      compare_value("frag_o.last", 64'(want.last), 64'(got.last));
      sum = sum + got.len;
    end
    compare_value("fragment length sum", 64'(len), 64'(sum));
  endtask

  task automatic wait_done(input logic [IdWidth-1:0] id);
    logic [63:0] data;
    data = '0;
    while (data != 64'(id)) reg_read(RegDoneId, data);
    reg_idle();
  endtask

  // Status read clears the sticky error
  task automatic check_status(input logic err);
    logic [63:0] data;
    reg_read(RegStatus, data);
    compare_value("RegStatus", {62'd0, err, 1'b0}, data);
    reg_read(RegStatus, data);
    compare_value("RegStatus", 64'd0, data);
    reg_idle();
  endtask

  task automatic run_row(input int i);
    logic [63:0] id;
    int          fails;
    int          frags;
    fails = fail_cnt;
    frags = frag_cnt;
    reg_write(RegSrc, 64'(rows[i].src));
    reg_write(RegDst, 64'(rows[i].dst));
    reg_write(RegLen, 64'(rows[i].len));
    if (rows[i].len != '0) begin
      last_id = last_id + 1'b1;
      job_err_q.push_back(rows[i].inject_err);
      build_expected(rows[i].src, rows[i].dst, rows[i].len);
    end
    reg_read(RegNextId, id);
    reg_idle();
    compare_value("RegNextId", (rows[i].len != '0) ? 64'(last_id) : 64'd0, id);
    if (rows[i].len != '0) begin
      compare_frags(rows[i].len);
      wait_done(last_id);
    end else begin
      repeat (20) @(posedge clk_i);
      reg_read(RegDoneId, id);
      reg_idle();
      compare_value("RegDoneId", 64'(last_id), id);
    end
    compare_value("fragment count", 64'(rows[i].num_frags), 64'(frag_cnt - frags));
    compare_value("extra fragments", 64'd0, 64'(frag_q.size()));
    check_status(rows[i].inject_err);
    $display("test %0d: %s", i, (fails == fail_cnt) ? "ok" : "mismatch");
  endtask

  // Stalled mover, launches until the job credits run out
  task automatic run_credits();
    logic [63:0] id;
    int          fails;
    int          frags;
    fails = fail_cnt;
    frags = frag_cnt;
    hold_ready = 1'b1;
    reg_write(RegSrc, 64'(rows[0].src));
    reg_write(RegDst, 64'(rows[0].dst));
    reg_write(RegLen, 64'(rows[0].len));
    for (int k = 0; k < JobFifoDepth + 3; k++) begin
      reg_read(RegNextId, id);
      if (k <= JobFifoDepth) begin
        last_id = last_id + 1'b1;
        job_err_q.push_back(1'b0);
        build_expected(rows[0].src, rows[0].dst, rows[0].len);
        compare_value("RegNextId", 64'(last_id), id);
      end else begin
        compare_value("RegNextId", 64'd0, id);
      end
    end
    reg_idle();
    hold_ready = 1'b0;
    compare_frags((JobFifoDepth + 1) * rows[0].len);
    wait_done(last_id);
    compare_value("fragment count", 64'((JobFifoDepth + 1) * rows[0].num_frags),
                  64'(frag_cnt - frags));
    check_status(1'b0);
    $display("test credits: %s", (fails == fail_cnt) ? "ok" : "mismatch");
  endtask

  initial begin
    rst_n_i = 1'b0;
    reg_req_i = '0;
    frag_ready_i = 1'b0;
    rsp_valid_i = 1'b0;
    rsp_i = '0;
    rows[0] = '{48'h1000, 48'h2000, 32'h100, 1'b0, 8'd1};
    rows[1] = '{48'h1f80, 48'h3fc0, 32'h200, 1'b0, 8'd3};
    rows[2] = '{48'h0800, 48'h5a00, 32'h3000, 1'b0, 8'd7};
    rows[3] = '{48'h4000, 48'h6000, 32'h0, 1'b0, 8'd0};
    rows[4] = '{48'h7ff0, 48'h9000, 32'h40, 1'b1, 8'd2};
    repeat (16) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    for (int i = 0; i < NumRows; i++) run_row(i);
    run_credits();
    $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
